//--- memArbiter.f
src/memArbPkg.sv
src/burstIf.sv
src/beatIf.sv
src/requestArbiter.sv
src/burstSequencer.sv
src/cacheFillDemux.sv
src/memArbiterTop.sv
bench/ddrMemModel.sv
bench/memArbiterTb.sv

//--- bench/memArbiterTb.sv
`timescale 1ns/10ps

module memArbiterTb import memArbPkg::*; ();

	localparam int NUM_OPS = 47;	// 7 directed plus 40 random

	logic                    gpuClk;
	logic                    resetX;
	logic [MEM_CMD_W-1:0]    cmd;
	logic                    memBusy;
	logic [1:0]              texReq, texComplete, clutReq, clutComplete;	// [0] left
	logic [TEX_ADR_W-1:0]    texAdr [2];
	logic [CLUT_ADR_W-1:0]   clutAdr [2];
	logic                    texWrite, clutWrite;
	logic [2*DDR_DATA_W-1:0] texData;
	logic [2:0]              clutIndex, cnt;
	logic [DDR_DATA_W-1:0]   clutData, memWrData, memRdData;
	logic [VRAM_ADR_W-1:0]   memAdr;
	logic [3:0]              memSel;
	logic                    memWrt, memReq, memAck;

	integer      seed;
	string       testName;
	logic [55:0] expWrites [$];	// {adr, dat, sel}
	logic [36:0] expClut [$];	// {side, last, index, data}
	logic [64:0] expTex [$];	// {side, data}
	logic [2:0]  expBeatCnt [$];	// cnt_o per burst, in service order
	logic [2:0]  burstCnt;		// Expected cnt_o of the open burst
	logic        inBurst;
	int          issued [4];	// CLUT L, CLUT R, TEX L, TEX R
	int          completed [4];
	realtime     clutDoneAt, texDoneAt;

	memArbiterTop #(.VRAM_ADR_W(VRAM_ADR_W)) UUT (
		.gpuClk(gpuClk), .resetX(resetX), .cmd_i(cmd), .memBusy_o(memBusy),
		.texReqL_i(texReq[0]), .texReqR_i(texReq[1]),
		.texAdrL_i(texAdr[0]), .texAdrR_i(texAdr[1]),
		.texCompleteL_o(texComplete[0]), .texCompleteR_o(texComplete[1]),
		.texWrite_o(texWrite), .texData_o(texData),
		.clutReqL_i(clutReq[0]), .clutReqR_i(clutReq[1]),
		.clutAdrL_i(clutAdr[0]), .clutAdrR_i(clutAdr[1]),
		.clutCompleteL_o(clutComplete[0]), .clutCompleteR_o(clutComplete[1]),
		.clutWrite_o(clutWrite), .clutIndex_o(clutIndex), .clutData_o(clutData),
		.adr_o(memAdr), .dat_o(memWrData), .sel_o(memSel), .cnt_o(cnt),
		.wrt_o(memWrt), .req_o(memReq), .dat_i(memRdData), .ack_i(memAck)
	);

	ddrMemModel memModel (
		.gpuClk(gpuClk), .resetX(resetX), .adr_i(memAdr), .dat_i(memWrData), .sel_i(memSel),
		.wrt_i(memWrt), .req_i(memReq), .dat_o(memRdData), .ack_o(memAck)
	);

	always #4 gpuClk = ~gpuClk;	// 8 ns period

	// --------------------
	// Reference model
	// --------------------
	function automatic logic [31:0] readWord(input logic [VRAM_ADR_W-1:0] a);
		return {12'd0, a} ^ 32'hA5A5_0000;
	endfunction

	// Bus beat i of a GPU command as {adr, dat, sel}
	function automatic logic [55:0] cmdBeat(input memCmdT c, input int i);
		logic [VRAM_ADR_W-1:0] a;
		a = {c.blockAdr, 5'd0};	// 32-byte block
		if (c.opCode == MEM_FILL)
			return {a + VRAM_ADR_W'(4 * i), c.colorL, c.colorL, 4'hF};
		return {a + VRAM_ADR_W'({c.pairId, 2'd0}), c.colorR, c.colorL,
			{2{c.validPair[1]}}, {2{c.validPair[0]}}};
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string what, input logic [63:0] expV, actV);
		failRun($sformatf("MISMATCH %s %s: expected %h, actual %h", testName, what, expV, actV));
	endtask

	task automatic nextCycle();
		@(posedge gpuClk);
		#1;	// Drive point
	endtask

	task automatic sendCmd(input memCmdT c);
		int beats;
		beats = (c.opCode == MEM_FILL) ? BEATS_FILL : BEATS_PIX;
		for (int i = 0; i < beats; i++)
			expWrites.push_back(cmdBeat(c, i));
		expBeatCnt.push_back(3'(beats - 1));
		while (memBusy)
			nextCycle();	// GPU waits for idle
		cmd = c;
		nextCycle();
		cmd = '0;
		while (memBusy)
			nextCycle();
	endtask

	task automatic expectClut(input logic side, input logic [CLUT_ADR_W-1:0] a);
		for (int i = 0; i < BEATS_CLUT; i++)
			expClut.push_back({side, i == BEATS_CLUT - 1, 3'(i),
				readWord({a, 5'd0} + VRAM_ADR_W'(4 * i))});
		expBeatCnt.push_back(3'(BEATS_CLUT - 1));
		issued[side]++;
	endtask

	task automatic expectTex(input logic side, input logic [TEX_ADR_W-1:0] a);
		expTex.push_back({side, readWord({a, 3'd0} + VRAM_ADR_W'(4)), readWord({a, 3'd0})});
		expBeatCnt.push_back(3'(BEATS_TEX - 1));
		issued[2 + side]++;
	endtask

	// Requests are levels held until their own completion
	task automatic holdClut(input logic side, input logic [CLUT_ADR_W-1:0] a);
		clutAdr[side] = a;
		clutReq[side] = 1'b1;
		do
			nextCycle();
		while (!clutComplete[side]);
		clutReq[side] = 1'b0;
	endtask

	task automatic holdTex(input logic side, input logic [TEX_ADR_W-1:0] a);
		texAdr[side] = a;
		texReq[side] = 1'b1;
		do
			nextCycle();
		while (!texComplete[side]);
		texReq[side] = 1'b0;
	endtask

	// Last cache word lands with its completion, compared at the next negedge
	task automatic checkDrained();
		nextCycle();
		assert (expWrites.size() == 0 && expClut.size() == 0 && expTex.size() == 0
			&& expBeatCnt.size() == 0)
			else failRun($sformatf("%s left expected results unseen", testName));
	endtask

	// --------------------
	// Compare at mid-cycle
	// --------------------
	always @(negedge gpuClk) begin : compare
		logic [55:0] w;
		logic [36:0] ce;
		logic [64:0] te;
		if (!resetX) begin
			if (memReq) begin
				if (!inBurst) begin
					assert (expBeatCnt.size() > 0)
						else failRun("burst request with nothing issued behind it");
					burstCnt = expBeatCnt.pop_front();
					inBurst  = 1'b1;
				end
				assert (cnt == burstCnt) else reportMismatch("beat count", burstCnt, cnt);
			end else begin
				inBurst = 1'b0;
			end
			while (memModel.writeLog.size() > 0) begin
				w = memModel.writeLog.pop_front();
				assert (expWrites.size() > 0) else failRun("write beat with no command behind it");
				assert (w == expWrites[0]) else reportMismatch("write beat", expWrites[0], w);
				void'(expWrites.pop_front());
			end
			if (clutWrite) begin
				assert (expClut.size() > 0) else failRun("CLUT write with no request behind it");
				ce = expClut.pop_front();
				assert ({clutIndex, clutData} == ce[34:0])
					else reportMismatch("CLUT word", ce[34:0], {clutIndex, clutData});
				assert (clutComplete == (ce[35] ? {ce[36], !ce[36]} : 2'b00))
					else reportMismatch("CLUT complete", {ce[35] & ce[36], ce[35] & !ce[36]},
						clutComplete);
			end else begin
				assert (clutComplete == 2'b00) else failRun("CLUT complete without a write");
			end
			if (texWrite) begin
				assert (expTex.size() > 0) else failRun("texture write with no request behind it");
				te = expTex.pop_front();
				assert (texData == te[63:0]) else reportMismatch("texture word", te[63:0], texData);
				assert (texComplete == {te[64], !te[64]})
					else reportMismatch("texture complete", {te[64], !te[64]}, texComplete);
			end else begin
				assert (texComplete == 2'b00) else failRun("texture complete without a write");
			end
			if (clutComplete != 2'b00)
				clutDoneAt = $realtime;
			if (texComplete != 2'b00)
				texDoneAt = $realtime;
			completed[0] += clutComplete[0];
			completed[1] += clutComplete[1];
			completed[2] += texComplete[0];
			completed[3] += texComplete[1];
		end
	end

	// Fixed budget per operation
	initial begin
		repeat (NUM_OPS * 200) @(posedge gpuClk);
		failRun("timeout, a burst or a completion never arrived");
	end

	// --------------------
	// Stimulus
	// --------------------
	initial begin
		memCmdT                c;
		int                    kind;
		logic                  side;
		logic [TEX_ADR_W-1:0]  lineAdr;
		seed       = 32'h11da_8d34;
		gpuClk     = 1'b0;
		resetX     = 1'b1;
		cmd        = '0;
		texReq     = '0;
		clutReq    = '0;
		texAdr     = '{default: '0};
		clutAdr    = '{default: '0};
		inBurst    = 1'b0;
		repeat (3) @(posedge gpuClk);
		#1;
		resetX = 1'b0;
		testName = "reset";
		assert (!memReq && !memWrt && !memBusy && !texWrite && !clutWrite
			&& clutComplete == 2'b00 && texComplete == 2'b00)
			else failRun("outputs not low after reset");

		testName = "pixel pair";
		sendCmd('{16'h1234, 16'hABCD, 2'b10, 15'h0123, 3'd5, 1'b0, MEM_PIXEL2VRAM});
		checkDrained();
		testName = "block fill";
		sendCmd('{16'h7E0F, 16'h0000, 2'b00, 15'h2A5C, 3'd0, 1'b0, MEM_FILL});
		checkDrained();

		testName = "CLUT left and right";	// Left queued first
		expectClut(1'b0, 15'h0042);
		expectClut(1'b1, 15'h1234);
		fork
			holdClut(1'b0, 15'h0042);
			holdClut(1'b1, 15'h1234);
		join
		checkDrained();

		testName = "texture";
		expectTex(1'b1, 17'h0_3A07);
		holdTex(1'b1, 17'h0_3A07);
		checkDrained();

		testName = "CLUT before texture";
		expectClut(1'b1, 15'h7FFF);
		expectTex(1'b0, 17'h1_0001);
		fork
			holdClut(1'b1, 15'h7FFF);
			holdTex(1'b0, 17'h1_0001);
		join
		checkDrained();
		assert (clutDoneAt < texDoneAt) else failRun("texture refill finished before the CLUT refill");

		testName = "random mix";
		for (int n = 0; n < 40; n++) begin
			kind    = {$random(seed)} % 4;
			side    = $random(seed);
			lineAdr = $random(seed);
			c       = MEM_CMD_W'({$random(seed), $random(seed)});
			c.spare = 1'b0;
			if (kind < 2) begin
				c.opCode = (kind == 0) ? MEM_PIXEL2VRAM : MEM_FILL;
				sendCmd(c);
			end else if (kind == 2) begin
				expectClut(side, lineAdr[CLUT_ADR_W-1:0]);
				holdClut(side, lineAdr[CLUT_ADR_W-1:0]);
			end else begin
				expectTex(side, lineAdr);
				holdTex(side, lineAdr);
			end
		end

		repeat (2) nextCycle();	// Busy drops after done
		testName = "final";
		checkDrained();
		foreach (issued[i])
			assert (issued[i] == completed[i])
				else reportMismatch("completion count", issued[i], completed[i]);
		if (!memBusy && !memReq) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			failRun("memory bus still busy after the last completion");
		end
	end

endmodule

//--- bench/ddrMemModel.sv
`timescale 1ns/10ps

// Burst memory with random wait states and a write log
module ddrMemModel import memArbPkg::*; (
	input  logic                  gpuClk,
	input  logic                  resetX,
	input  logic [VRAM_ADR_W-1:0] adr_i,
	input  logic [DDR_DATA_W-1:0] dat_i,	// Write data
	input  logic [3:0]            sel_i,
	input  logic                  wrt_i,
	input  logic                  req_i,
	output logic [DDR_DATA_W-1:0] dat_o,	// Read data
	output logic                  ack_o
);

	integer      seed;
	int          waitLeft;		// Idle cycles before the next ack
	logic [55:0] writeLog [$];	// {adr, dat, sel} per write beat

	// Beats change 1 ns after the edge, like the rest of the stimulus
	initial begin
		seed     = 32'h11da_8d34;
		waitLeft = 0;
		ack_o    = 1'b0;
		dat_o    = '0;
		forever begin
			@(posedge gpuClk);
			#1;
			ack_o = 1'b0;	// One cycle per beat
			if (req_i && !resetX) begin
				if (waitLeft == 0) begin
					ack_o = 1'b1;
					dat_o = {12'd0, adr_i} ^ 32'hA5A5_0000;	// Read rule
					if (wrt_i)
						writeLog.push_back({adr_i, dat_i, sel_i});	// Stable all cycle
					waitLeft = {$random(seed)} % 4;	// 0 to 3 wait states
				end else begin
					waitLeft--;
				end
			end
		end
	end

endmodule

//--- src/memArbiterTop.sv
`timescale 1ns/10ps

module memArbiterTop import memArbPkg::*; #(
	parameter int VRAM_ADR_W = memArbPkg::VRAM_ADR_W
) (
	input  logic                    gpuClk,
	input  logic                    resetX,
	// --------------------
	// GPU command
	input  logic [MEM_CMD_W-1:0]    cmd_i,
	output logic                    memBusy_o,
	// --------------------
	// TEX cache
	input  logic                    texReqL_i,
	input  logic                    texReqR_i,
	input  logic [TEX_ADR_W-1:0]    texAdrL_i,
	input  logic [TEX_ADR_W-1:0]    texAdrR_i,
	output logic                    texCompleteL_o,
	output logic                    texCompleteR_o,
	output logic                    texWrite_o,
	output logic [2*DDR_DATA_W-1:0] texData_o,
	// --------------------
	// CLUT cache
	input  logic                    clutReqL_i,
	input  logic                    clutReqR_i,
	input  logic [CLUT_ADR_W-1:0]   clutAdrL_i,
	input  logic [CLUT_ADR_W-1:0]   clutAdrR_i,
	output logic                    clutCompleteL_o,
	output logic                    clutCompleteR_o,
	output logic                    clutWrite_o,
	output logic [2:0]              clutIndex_o,
	output logic [DDR_DATA_W-1:0]   clutData_o,
	// --------------------
	// Memory bus
	output logic [VRAM_ADR_W-1:0]   adr_o,
	output logic [DDR_DATA_W-1:0]   dat_o,
	output logic [3:0]              sel_o,
	output logic [2:0]              cnt_o,
	output logic                    wrt_o,
	output logic                    req_o,
	input  logic [DDR_DATA_W-1:0]   dat_i,
	input  logic                    ack_i
);

	burstIf #(.VRAM_ADR_W(VRAM_ADR_W)) burstBus ();	// Arbiter to sequencer
	beatIf beatBus ();								// Sequencer to fill logic

	requestArbiter #(.VRAM_ADR_W(VRAM_ADR_W)) arbInst (
		.gpuClk     (gpuClk),
		.resetX     (resetX),
		.cmd_i      (cmd_i),
		.texReqL_i  (texReqL_i),
		.texReqR_i  (texReqR_i),
		.texAdrL_i  (texAdrL_i),
		.texAdrR_i  (texAdrR_i),
		.clutReqL_i (clutReqL_i),
		.clutReqR_i (clutReqR_i),
		.clutAdrL_i (clutAdrL_i),
		.clutAdrR_i (clutAdrR_i),
		.memBusy_o  (memBusy_o),
		.bus        (burstBus.arb)
	);

	burstSequencer #(.VRAM_ADR_W(VRAM_ADR_W)) seqInst (
		.gpuClk (gpuClk),
		.resetX (resetX),
		.adr_o  (adr_o),
		.dat_o  (dat_o),
		.sel_o  (sel_o),
		.cnt_o  (cnt_o),
		.wrt_o  (wrt_o),
		.req_o  (req_o),
		.dat_i  (dat_i),
		.ack_i  (ack_i),
		.bus    (burstBus.seq),
		.beat   (beatBus.seq)
	);

	cacheFillDemux fillInst (
		.gpuClk          (gpuClk),
		.resetX          (resetX),
		.beat            (beatBus.fill),
		.texWrite_o      (texWrite_o),
		.texData_o       (texData_o),
		.texCompleteL_o  (texCompleteL_o),
		.texCompleteR_o  (texCompleteR_o),
		.clutWrite_o     (clutWrite_o),
		.clutIndex_o     (clutIndex_o),
		.clutData_o      (clutData_o),
		.clutCompleteL_o (clutCompleteL_o),
		.clutCompleteR_o (clutCompleteR_o)
	);

endmodule

//--- src/cacheFillDemux.sv
`timescale 1ns/10ps

module cacheFillDemux import memArbPkg::*; (
	input  logic                    gpuClk,
	input  logic                    resetX,
	beatIf.fill                     beat,
	// TEX cache
	output logic                    texWrite_o,
	output logic [2*DDR_DATA_W-1:0] texData_o,		// {beat 1, beat 0}
	output logic                    texCompleteL_o,
	output logic                    texCompleteR_o,
	// CLUT cache
	output logic                    clutWrite_o,
	output beatIdxT                 clutIndex_o,
	output logic [DDR_DATA_W-1:0]   clutData_o,
	output logic                    clutCompleteL_o,
	output logic                    clutCompleteR_o
);

	logic                  clutBeat;
	logic                  texBeat;
	logic [DDR_DATA_W-1:0] texLowQ;	// First half of the texture line

	assign clutBeat = beat.beatValid && (beat.kind == BURST_CLUT);
	assign texBeat  = beat.beatValid && (beat.kind == BURST_TEX);

	// --------------------
	// Strobes
	// --------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			clutWrite_o     <= 1'b0;
			clutCompleteL_o <= 1'b0;
			clutCompleteR_o <= 1'b0;
			texWrite_o      <= 1'b0;
			texCompleteL_o  <= 1'b0;
			texCompleteR_o  <= 1'b0;
		end else begin
			clutWrite_o     <= clutBeat;	// One write per beat
			clutCompleteL_o <= clutBeat && beat.last && !beat.sideR;
			clutCompleteR_o <= clutBeat && beat.last && beat.sideR;
			texWrite_o      <= texBeat && beat.last;	// Whole line at once
			texCompleteL_o  <= texBeat && beat.last && !beat.sideR;
			texCompleteR_o  <= texBeat && beat.last && beat.sideR;
		end
	end

	// --------------------
	// Payload
	// --------------------
	always_ff @(posedge gpuClk) begin
		if (clutBeat) begin
			clutIndex_o <= beat.beatIdx;
			clutData_o  <= beat.beatData;
		end
		if (texBeat && !beat.last) begin
			texLowQ <= beat.beatData;		// Park beat 0
		end
		if (texBeat && beat.last) begin
			texData_o <= {beat.beatData, texLowQ};
		end
	end

	// Only one burst is ever in flight
	assert property (@(posedge gpuClk) disable iff (resetX)
		!(texWrite_o && clutWrite_o));

endmodule

//--- src/burstSequencer.sv
`timescale 1ns/10ps

module burstSequencer import memArbPkg::*; #(
	parameter int VRAM_ADR_W = memArbPkg::VRAM_ADR_W
) (
	input  logic                  gpuClk,
	input  logic                  resetX,
	// Memory bus
	output logic [VRAM_ADR_W-1:0] adr_o,
	output logic [DDR_DATA_W-1:0] dat_o,
	output logic [3:0]            sel_o,
	output beatIdxT               cnt_o,	// Beats minus 1
	output logic                  wrt_o,
	output logic                  req_o,
	input  logic [DDR_DATA_W-1:0] dat_i,
	input  logic                  ack_i,	// One beat per cycle high
	// Internal
	burstIf.seq                   bus,
	beatIf.seq                    beat
);

	logic    reqQ;
	beatIdxT beatCnt;	// Acked beats so far
	logic    doneQ;
	logic    isWrite;
	logic    lastHit;	// Current beat is the final one
	logic    beatAck;

	assign isWrite = (bus.kind == BURST_PIXPAIR) || (bus.kind == BURST_FILL);
	assign lastHit = (beatCnt == bus.lastBeat);
	assign beatAck = reqQ && ack_i;

	// --------------------
	// Request and beat counter
	// --------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			reqQ    <= 1'b0;
			beatCnt <= '0;
			doneQ   <= 1'b0;
		end else begin
			doneQ <= 1'b0;
			if (bus.start) begin
				reqQ    <= 1'b1;		// Cycle after start
				beatCnt <= '0;
			end else if (beatAck) begin
				if (lastHit) begin
					reqQ  <= 1'b0;		// Drop with done
					doneQ <= 1'b1;
				end else begin
					beatCnt <= beatCnt + 3'd1;
				end
			end
		end
	end

	assign bus.done = doneQ;

	// --------------------
	// Bus outputs
	// --------------------
	// Pixel pair sits at one word, others walk the line
	always_comb begin
		if (bus.kind == BURST_PIXPAIR) begin
			adr_o = bus.baseAdr;
		end else begin
			adr_o = bus.baseAdr + VRAM_ADR_W'({beatCnt, 2'd0});
		end
	end

	assign dat_o = bus.wrData;	// Constant over the burst
	assign sel_o = bus.wrSel;
	assign cnt_o = bus.lastBeat;
	assign req_o = reqQ;
	assign wrt_o = reqQ && isWrite;

	// --------------------
	// Read beats to fill logic
	// --------------------
	assign beat.beatValid = beatAck && !isWrite;
	assign beat.beatIdx   = beatCnt;
	assign beat.beatData  = dat_i;
	assign beat.kind      = bus.kind;
	assign beat.sideR     = bus.sideR;
	assign beat.last      = lastHit;

	// Memory only answers an open request
	assert property (@(posedge gpuClk) disable iff (resetX)
		ack_i |-> req_o);

	// Request held until final beat is acked
	assert property (@(posedge gpuClk) disable iff (resetX)
		(req_o && !(ack_i && lastHit)) |=> req_o);

endmodule

//--- src/requestArbiter.sv
`timescale 1ns/10ps

module requestArbiter import memArbPkg::*; #(
	parameter int VRAM_ADR_W = memArbPkg::VRAM_ADR_W
) (
	input  logic                  gpuClk,
	input  logic                  resetX,
	input  logic [MEM_CMD_W-1:0]  cmd_i,		// Strobe, only while not busy
	input  logic                  texReqL_i,
	input  logic                  texReqR_i,
	input  logic [TEX_ADR_W-1:0]  texAdrL_i,
	input  logic [TEX_ADR_W-1:0]  texAdrR_i,
	input  logic                  clutReqL_i,
	input  logic                  clutReqR_i,
	input  logic [CLUT_ADR_W-1:0] clutAdrL_i,
	input  logic [CLUT_ADR_W-1:0] clutAdrR_i,
	output logic                  memBusy_o,
	burstIf.arb                   bus
);

	memCmdT                cmdW;
	logic                  cmdValid;
	logic                  grantAny;	// Something to serve this cycle
	logic                  busyQ;
	burstKindT             kindN;
	logic                  sideN;
	logic [VRAM_ADR_W-1:0] adrN;
	beatIdxT               lastN;
	logic [DDR_DATA_W-1:0] datN;
	logic [3:0]            selN;
	logic [CLUT_ADR_W-1:0] clutAdrSel;	// Left wins when both ask
	logic [TEX_ADR_W-1:0]  texAdrSel;

	assign cmdW       = memCmdT'(cmd_i);
	assign cmdValid   = (cmdW.opCode != MEM_NONE);
	assign clutAdrSel = clutReqL_i ? clutAdrL_i : clutAdrR_i;
	assign texAdrSel  = texReqL_i ? texAdrL_i : texAdrR_i;

	// --------------------
	// Priority and decode
	// --------------------
	// Command > CLUT L > CLUT R > TEX L > TEX R
	always_comb begin
		grantAny = 1'b1;
		kindN    = BURST_PIXPAIR;
		sideN    = 1'b0;
		adrN     = '0;
		lastN    = '0;
		datN     = '0;		// Don't care on reads
		selN     = 4'hF;
		if (cmdValid) begin
			if (cmdW.opCode == MEM_FILL) begin
				kindN = BURST_FILL;
				adrN  = VRAM_ADR_W'({cmdW.blockAdr, 5'd0});
				lastN = beatIdxT'(BEATS_FILL - 1);
				datN  = {cmdW.colorL, cmdW.colorL};	// Same colour both halves
			end else begin
				kindN = BURST_PIXPAIR;
				adrN  = VRAM_ADR_W'({cmdW.blockAdr, cmdW.pairId, 2'd0});
				lastN = beatIdxT'(BEATS_PIX - 1);
				datN  = {cmdW.colorR, cmdW.colorL};
				selN  = {{2{cmdW.validPair[1]}}, {2{cmdW.validPair[0]}}};	// 2 bytes/pixel
			end
		end else if (clutReqL_i || clutReqR_i) begin
			kindN = BURST_CLUT;
			sideN = !clutReqL_i;
			adrN  = VRAM_ADR_W'({clutAdrSel, 5'd0});	// 32-byte line
			lastN = beatIdxT'(BEATS_CLUT - 1);
		end else if (texReqL_i || texReqR_i) begin
			kindN = BURST_TEX;
			sideN = !texReqL_i;
			adrN  = VRAM_ADR_W'({texAdrSel, 3'd0});		// 8-byte line
			lastN = beatIdxT'(BEATS_TEX - 1);
		end else begin
			grantAny = 1'b0;
		end
	end

	// --------------------
	// Busy and start
	// --------------------
	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			busyQ     <= 1'b0;
			bus.start <= 1'b0;
		end else begin
			bus.start <= 1'b0;
			if (!busyQ && grantAny) begin
				busyQ     <= 1'b1;	// Set on grant
				bus.start <= 1'b1;
			end else if (bus.done) begin
				busyQ     <= 1'b0;	// Idle again next cycle
			end
		end
	end

	// Descriptor latch, held until done
	always_ff @(posedge gpuClk) begin
		if (!busyQ && grantAny) begin
			bus.kind     <= kindN;
			bus.sideR    <= sideN;
			bus.baseAdr  <= adrN;
			bus.lastBeat <= lastN;
			bus.wrData   <= datN;
			bus.wrSel    <= selN;
		end
	end

	assign memBusy_o = busyQ;

	// GPU must wait for memBusy_o low
	assert property (@(posedge gpuClk) disable iff (resetX)
		busyQ |-> (cmdW.opCode == MEM_NONE));

	// No second burst before the sequencer reports done
	assert property (@(posedge gpuClk) disable iff (resetX)
		bus.start |=> (!bus.start until_with bus.done));

endmodule

//--- src/beatIf.sv
`timescale 1ns/10ps

// One strobe per acknowledged read beat, no back-pressure
interface beatIf import memArbPkg::*; ();

	logic                  beatValid;	// Ack of a read beat
	beatIdxT               beatIdx;		// Position inside the burst
	logic [DDR_DATA_W-1:0] beatData;	// dat_i of that beat
	burstKindT             kind;		// CLUT or TEX
	logic                  sideR;		// Requesting side
	logic                  last;		// Final beat of the burst

	modport seq (
		output beatValid, beatIdx, beatData, kind, sideR, last
	);

	modport fill (
		input  beatValid, beatIdx, beatData, kind, sideR, last
	);

endinterface

//--- src/burstIf.sv
`timescale 1ns/10ps

// Granted burst descriptor, arbiter to sequencer
interface burstIf import memArbPkg::*; #(
	parameter int VRAM_ADR_W = memArbPkg::VRAM_ADR_W
) ();

	logic                  start;		// One-cycle strobe, idle only
	burstKindT             kind;
	logic                  sideR;		// 0 left, 1 right
	logic [VRAM_ADR_W-1:0] baseAdr;		// Byte address of beat 0
	beatIdxT               lastBeat;	// Beat count minus 1
	logic [DDR_DATA_W-1:0] wrData;		// Write payload
	logic [3:0]            wrSel;		// Byte enables
	logic                  done;		// Strobe after last acked beat

	// Descriptor held stable from start until done
	modport arb (
		output start, kind, sideR, baseAdr, lastBeat, wrData, wrSel,
		input  done
	);

	modport seq (
		input  start, kind, sideR, baseAdr, lastBeat, wrData, wrSel,
		output done
	);

endinterface

//--- src/memArbPkg.sv
package memArbPkg;

	// --------------------
	// Widths
	// --------------------
	localparam int VRAM_ADR_W = 20;	// Byte address, 1 MB of VRAM
	localparam int DDR_DATA_W = 32;	// One beat on the memory bus
	localparam int TEX_ADR_W  = 17;	// Texture line, 8-byte units
	localparam int CLUT_ADR_W = 15;	// CLUT line, 32-byte units
	localparam int MEM_CMD_W  = 56;	// GPU command word

	// --------------------
	// Command word
	// --------------------
	typedef enum logic [2:0] {
		MEM_NONE       = 3'd0,	// Nothing this cycle
		MEM_PIXEL2VRAM = 3'd1,	// Masked pixel pair
		MEM_FILL       = 3'd2	// One colour over a block
	} memOpT;

	// Packed from the MSB down, 56 bits in total
	typedef struct packed {
		logic [15:0] colorL;	// Left pixel, also fill colour
		logic [15:0] colorR;	// Right pixel
		logic [1:0]  validPair;	// Per-pixel write enable
		logic [14:0] blockAdr;	// 32-byte block
		logic [2:0]  pairId;	// Word inside the block
		logic        spare;
		memOpT       opCode;
	} memCmdT;

	// --------------------
	// Bursts
	// --------------------
	typedef enum logic [1:0] {
		BURST_PIXPAIR,	// Single masked write
		BURST_FILL,		// 8 writes
		BURST_CLUT,		// 8 reads
		BURST_TEX		// 2 reads
	} burstKindT;

	// Beat counts per burst kind
	localparam int BEATS_PIX  = 1;
	localparam int BEATS_FILL = 8;
	localparam int BEATS_CLUT = 8;
	localparam int BEATS_TEX  = 2;

	typedef logic [2:0] beatIdxT;	// Up to 8 beats

endpackage
